//--- design/eth_tx_pkg.sv
package eth_tx_pkg;

    // --------------------------------------------------------------------------
    // framing
    // --------------------------------------------------------------------------
    localparam int          preamble_len     = 7;
    localparam logic [7:0]  preamble_byte    = 8'h55;
    localparam logic [7:0]  sfd_byte         = 8'hd5;
    localparam int          fcs_len          = 4;

    // header lengths in bytes
    localparam int          mac_hdr_len      = 14;
    localparam int          ip_hdr_len       = 20;
    localparam int          udp_hdr_len      = 8;

    // --------------------------------------------------------------------------
    // header field values
    // --------------------------------------------------------------------------
    localparam logic [15:0] ethertype_ipv4   = 16'h0800;
    localparam logic [7:0]  ip_ver_ihl       = 8'h45;       // version 4, 5 words
    localparam logic [7:0]  ip_proto_udp     = 8'h11;
    localparam logic [7:0]  ip_ttl           = 8'd64;
    localparam logic [15:0] ip_flags_df      = 16'h4000;    // don't fragment, offset 0

    // reflected crc-32
    localparam logic [31:0] crc_poly         = 32'hedb88320;
    localparam logic [31:0] crc_residue_init = 32'hffffffff;

    // --------------------------------------------------------------------------
    // state encodings
    // --------------------------------------------------------------------------
    typedef enum logic [1:0] {
        frame_idle,
        frame_preamble,
        frame_body,
        frame_fcs
    } frame_state_t;

    typedef enum logic [1:0] {
        layer_idle,
        layer_header,
        layer_payload
    } layer_state_t;

endpackage

//--- design/crc32.sv
`timescale 1ns/1ps

module crc32 (
    input  logic        clk,
    input  logic        reset,
    input  logic        clear,
    input  logic        enable,
    input  logic [7:0]  din,
    output logic [31:0] dout
);

    import eth_tx_pkg::*;

    logic [31:0] crc_q;

    // lsb-first update, one bit per iteration
    function automatic logic [31:0] crc_byte(input logic [31:0] crc,
                                             input logic [7:0]  data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            crc_q <= crc_residue_init;
        end else if (enable) begin
            crc_q <= crc_byte(crc_q, din);
        end
    end

    assign dout = ~crc_q;   // fcs value, low byte goes first

endmodule

//--- design/udp_tx.sv
`timescale 1ns/1ps

module udp_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs,
    input  logic [15:0] src_port,
    input  logic [15:0] det_port,
    input  logic [15:0] data_len,
    output logic        fifo_rxen,
    input  logic [7:0]  fifo_rxd,
    output logic [7:0]  txd
);

    import eth_tx_pkg::*;

    layer_state_t state;
    logic [2:0]   cnt;          // header byte now on txd
    logic [63:0]  hdr_sr;
    logic [15:0]  rd_cnt;       // fifo reads still to issue
    logic         last_hdr;

    assign last_hdr  = (state == layer_header) && (cnt == 3'(udp_hdr_len - 1));

    // first read overlaps the last header byte so data follows with no gap
    assign fifo_rxen = (rd_cnt != 16'd0) && (last_hdr || state == layer_payload);

    assign txd = (state == layer_payload) ? fifo_rxd : hdr_sr[63:56];

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= layer_idle;
            cnt    <= 3'd0;
            rd_cnt <= 16'd0;
            hdr_sr <= 64'd0;
        end else if (fs) begin
            state  <= layer_header;
            cnt    <= 3'd0;
            rd_cnt <= data_len;
            hdr_sr <= {src_port, det_port, data_len + 16'(udp_hdr_len), 16'h0000};
        end else begin
            hdr_sr <= {hdr_sr[55:0], 8'h00};
            if (fifo_rxen) begin
                rd_cnt <= rd_cnt - 16'd1;
            end
            if (state == layer_header) begin
                cnt <= cnt + 3'd1;
                if (last_hdr) begin
                    state <= layer_payload;
                end
            end
        end
    end

endmodule

//--- design/ip_tx.sv
`timescale 1ns/1ps

module ip_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs,
    output logic        fs_udp,
    input  logic [15:0] data_len,
    input  logic [31:0] src_ip_addr,
    input  logic [31:0] det_ip_addr,
    input  logic [7:0]  udp_txd,
    output logic [7:0]  txd
);

    import eth_tx_pkg::*;

    layer_state_t state;
    logic [4:0]   cnt;          // header byte now on txd
    logic [4:0]   nxt;
    logic [7:0]   txd_r;
    logic [7:0]   nxt_byte;
    logic [15:0]  len_r;
    logic [31:0]  src_r;
    logic [31:0]  det_r;
    logic [15:0]  hw [10];      // header halfwords
    logic [19:0]  sum_q;
    logic [16:0]  fold1;
    logic [15:0]  fold2;
    logic [15:0]  cksum;

    // --------------------------------------------------------------------------
    // header halfwords
    // --------------------------------------------------------------------------
    always_comb begin
        hw[0] = {ip_ver_ihl, 8'h00};
        hw[1] = len_r + 16'(ip_hdr_len + udp_hdr_len);     // total length
        hw[2] = 16'h0000;                                   // identification
        hw[3] = ip_flags_df;
        hw[4] = {ip_ttl, ip_proto_udp};
        hw[5] = cksum;
        hw[6] = src_r[31:16];
        hw[7] = src_r[15:0];
        hw[8] = det_r[31:16];
        hw[9] = det_r[15:0];
    end

    // end-around carry, two folds cover a 20 bit sum
    assign fold1 = sum_q[15:0] + sum_q[19:16];
    assign fold2 = fold1[15:0] + fold1[16];

    assign nxt      = cnt + 5'd1;
    assign nxt_byte = nxt[0] ? hw[nxt[4:1]][7:0] : hw[nxt[4:1]][15:8];

    assign fs_udp = (state == layer_header) && (cnt == 5'(ip_hdr_len - 1));
    assign txd    = (state == layer_payload) ? udp_txd : txd_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= layer_idle;
            cnt   <= 5'd0;
            txd_r <= 8'h00;
        end else if (fs) begin
            state <= layer_header;
            cnt   <= 5'd0;
            txd_r <= ip_ver_ihl;
        end else if (state == layer_header) begin
            cnt <= nxt;
            if (fs_udp) begin
                state <= layer_payload;
            end else begin
                txd_r <= nxt_byte;
            end
        end
    end

    // fields and checksum pipeline, done by byte 3
    always_ff @(posedge clk) begin
        if (fs) begin
            len_r <= data_len;
            src_r <= src_ip_addr;
            det_r <= det_ip_addr;
        end
        if (state == layer_header && cnt == 5'd0) begin
            sum_q <= hw[0] + hw[1] + hw[2] + hw[3] + hw[4] + hw[6] + hw[7] + hw[8] + hw[9];
        end
        if (state == layer_header && cnt == 5'd1) begin
            cksum <= ~fold2;
        end
    end

endmodule

//--- design/mac_tx.sv
`timescale 1ns/1ps

module mac_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs,
    input  logic [47:0] src_mac_addr,
    input  logic [47:0] det_mac_addr,
    output logic        fs_ip,
    input  logic [7:0]  ip_txd,
    output logic [7:0]  txd
);

    import eth_tx_pkg::*;

    layer_state_t state;
    logic [3:0]   cnt;          // header byte now on txd
    logic [111:0] hdr_sr;

    assign fs_ip = (state == layer_header) && (cnt == 4'(mac_hdr_len - 1));
    assign txd   = (state == layer_payload) ? ip_txd : hdr_sr[111:104];

    // stays in payload until the next frame starts
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= layer_idle;
            cnt    <= 4'd0;
            hdr_sr <= 112'd0;
        end else if (fs) begin
            state  <= layer_header;
            cnt    <= 4'd0;
            hdr_sr <= {det_mac_addr, src_mac_addr, ethertype_ipv4};
        end else begin
            hdr_sr <= {hdr_sr[103:0], 8'h00};
            if (state == layer_header) begin
                cnt <= cnt + 4'd1;
                if (fs_ip) begin
                    state <= layer_payload;
                end
            end
        end
    end

endmodule

//--- design/frame_tx.sv
`timescale 1ns/1ps

module frame_tx (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs,
    output logic        fd,
    output logic        fs_mac,
    input  logic [7:0]  mac_txd,
    output logic        crc_clear,
    output logic        crc_en,
    input  logic [31:0] crc,
    output logic [7:0]  txd,
    output logic        tx_rdy,
    input  logic [15:0] frame_len
);

    import eth_tx_pkg::*;

    frame_state_t state;
    logic [15:0]  cnt;
    logic [15:0]  len_r;        // mac layer bytes in this frame
    logic [7:0]   txd_r;
    logic [7:0]   fcs_byte;

    assign crc_clear = fs && (state == frame_idle);
    assign crc_en    = (state == frame_body);
    assign fs_mac    = (state == frame_preamble) && (cnt == 16'(preamble_len));
    assign tx_rdy    = (state != frame_idle);
    assign fcs_byte  = crc[8*cnt[1:0] +: 8];

    always_comb begin
        case (state)
            frame_body: txd = mac_txd;
            frame_fcs:  txd = fcs_byte;
            default:    txd = txd_r;
        endcase
    end

    // --------------------------------------------------------------------------
    // frame sequencing
    // --------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= frame_idle;
            cnt   <= 16'd0;
            len_r <= 16'd0;
            txd_r <= 8'h00;
            fd    <= 1'b0;
        end else begin
            fd <= 1'b0;
            case (state)
                frame_idle: begin
                    if (fs) begin
                        state <= frame_preamble;
                        cnt   <= 16'd0;
                        len_r <= frame_len;
                        txd_r <= preamble_byte;
                    end
                end
                frame_preamble: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'(preamble_len - 1)) begin
                        txd_r <= sfd_byte;
                    end
                    if (fs_mac) begin   // sfd on the line
                        state <= frame_body;
                        cnt   <= 16'd0;
                        txd_r <= 8'h00;
                    end
                end
                frame_body: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == len_r - 16'd1) begin
                        state <= frame_fcs;
                        cnt   <= 16'd0;
                    end
                end
                default: begin
                    cnt <= cnt + 16'd1;
                    if (cnt == 16'(fcs_len - 1)) begin
                        state <= frame_idle;
                        fd    <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/mac_tx_top.sv
`timescale 1ns/1ps

module mac_tx_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        fs,
    input  logic [47:0] src_mac,
    input  logic [47:0] det_mac,
    input  logic [31:0] src_ip_addr,
    input  logic [31:0] det_ip_addr,
    input  logic [15:0] src_ip_port,
    input  logic [15:0] det_ip_port,
    input  logic [15:0] data_len,
    output logic        fifo_rxen,
    input  logic [7:0]  fifo_rxd,
    output logic [7:0]  txd,
    output logic        tx_rdy,
    output logic        fd
);

    import eth_tx_pkg::*;

    logic        fs_mac;
    logic        fs_ip;
    logic        fs_udp;
    logic [7:0]  mac_txd;
    logic [7:0]  ip_txd;
    logic [7:0]  udp_txd;
    logic        crc_clear;
    logic        crc_en;
    logic [31:0] crc;
    logic [15:0] frame_len;

    // bytes covered by the fcs
    assign frame_len = data_len + 16'(mac_hdr_len + ip_hdr_len + udp_hdr_len);

    frame_tx frame_tx_i (
        .clk       (clk),
        .reset     (reset),
        .fs        (fs),
        .fd        (fd),
        .fs_mac    (fs_mac),
        .mac_txd   (mac_txd),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc       (crc),
        .txd       (txd),
        .tx_rdy    (tx_rdy),
        .frame_len (frame_len)
    );

    mac_tx mac_tx_i (
        .clk          (clk),
        .reset        (reset),
        .fs           (fs_mac),
        .src_mac_addr (src_mac),
        .det_mac_addr (det_mac),
        .fs_ip        (fs_ip),
        .ip_txd       (ip_txd),
        .txd          (mac_txd)
    );

    ip_tx ip_tx_i (
        .clk         (clk),
        .reset       (reset),
        .fs          (fs_ip),
        .fs_udp      (fs_udp),
        .data_len    (data_len),
        .src_ip_addr (src_ip_addr),
        .det_ip_addr (det_ip_addr),
        .udp_txd     (udp_txd),
        .txd         (ip_txd)
    );

    udp_tx udp_tx_i (
        .clk       (clk),
        .reset     (reset),
        .fs        (fs_udp),
        .src_port  (src_ip_port),
        .det_port  (det_ip_port),
        .data_len  (data_len),
        .fifo_rxen (fifo_rxen),
        .fifo_rxd  (fifo_rxd),
        .txd       (udp_txd)
    );

    crc32 crc32_i (
        .clk    (clk),
        .reset  (reset),
        .clear  (crc_clear),
        .enable (crc_en),
        .din    (mac_txd),
        .dout   (crc)
    );

endmodule

//--- sim/mac_tx_props.sv
`timescale 1ns/1ps

module mac_tx_props (
    input logic                     clk,
    input logic                     reset,
    input logic                     fs,
    input logic                     tx_rdy,
    input logic                     fd,
    input logic                     fifo_rxen,
    input eth_tx_pkg::frame_state_t frame_state
);

    import eth_tx_pkg::*;

    assert property (@(posedge clk) reset |=> !tx_rdy && !fd)
        else $error("tx_rdy or fd high in the cycle after reset");

    // fd marks the first idle cycle
    assert property (@(posedge clk) disable iff (reset) fd |-> $past(tx_rdy) && !tx_rdy)
        else $error("fd without a falling tx_rdy");

    assert property (@(posedge clk) disable iff (reset) fd |=> !fd)
        else $error("fd longer than one cycle");

    assert property (@(posedge clk) disable iff (reset) fifo_rxen |-> tx_rdy)
        else $error("fifo_rxen outside a frame");

    // framer leaves idle only on fs
    assert property (@(posedge clk) disable iff (reset)
                     (frame_state == frame_idle) && !fs |=> !tx_rdy)
        else $error("tx_rdy rose while the framer was idle without fs");

endmodule

bind mac_tx_top mac_tx_props mac_tx_props_i (
    .clk         (clk),
    .reset       (reset),
    .fs          (fs),
    .tx_rdy      (tx_rdy),
    .fd          (fd),
    .fifo_rxen   (fifo_rxen),
    .frame_state (frame_tx_i.state)
);

//--- sim/tb_mac_tx_top.sv
`timescale 1ns/1ps

module tb_mac_tx_top;

    logic        clk;
    logic        reset;
    logic        fs;
    logic [47:0] src_mac;
    logic [47:0] det_mac;
    logic [31:0] src_ip_addr;
    logic [31:0] det_ip_addr;
    logic [15:0] src_ip_port;
    logic [15:0] det_ip_port;
    logic [15:0] data_len;
    logic        fifo_rxen;
    logic [7:0]  fifo_rxd = 8'h00;
    logic [7:0]  txd;
    logic        tx_rdy;
    logic        fd;

    // values for the next frame as applied by launch_frame
    logic [47:0] cfg_src_mac;
    logic [47:0] cfg_det_mac;
    logic [31:0] cfg_src_ip;
    logic [31:0] cfg_det_ip;
    logic [15:0] cfg_src_port;
    logic [15:0] cfg_det_port;
    logic [15:0] cfg_data_len;

    logic [7:0]  payload [0:255];
    logic [7:0]  exp_bytes [0:511];
    int          exp_len = 0;
    int          rd_ptr = 0;
    int          rx_idx = 0;
    int          rxen_cnt = 0;
    logic        rdy_q = 1'b0;
    integer      seed;

    mac_tx_top mac_tx_top_i (
        .clk         (clk),
        .reset       (reset),
        .fs          (fs),
        .src_mac     (src_mac),
        .det_mac     (det_mac),
        .src_ip_addr (src_ip_addr),
        .det_ip_addr (det_ip_addr),
        .src_ip_port (src_ip_port),
        .det_ip_port (det_ip_port),
        .data_len    (data_len),
        .fifo_rxen   (fifo_rxen),
        .fifo_rxd    (fifo_rxd),
        .txd         (txd),
        .tx_rdy      (tx_rdy),
        .fd          (fd)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // fifo model returns data one cycle after each read
    always @(posedge clk) begin
        if (fs && !tx_rdy) begin
            rd_ptr <= 0;
        end else if (fifo_rxen) begin
            fifo_rxd <= payload[rd_ptr[7:0]];
            rd_ptr   <= rd_ptr + 1;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    task automatic check_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %02h, got %02h", $time, name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_len(input string name, input logic [15:0] act, input logic [15:0] exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference frame
    // ------------------------------------------------------------------------
    function automatic logic [31:0] fcs_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[0] ^ b[k];               // data enters lsb first
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hedb88320;
            end
        end
        return c;
    endfunction

    function automatic int build_frame();
        int          n;
        logic [15:0] ip_hw [10];
        logic [15:0] udp_hw [4];
        logic [31:0] sum;
        logic [31:0] crc;
        n = 0;
        for (int i = 0; i < 7; i++) begin
            exp_bytes[n] = 8'h55;
            n++;
        end
        exp_bytes[n] = 8'hd5;
        n++;
        for (int i = 5; i >= 0; i--) begin
            exp_bytes[n] = cfg_det_mac[8*i +: 8];
            n++;
        end
        for (int i = 5; i >= 0; i--) begin
            exp_bytes[n] = cfg_src_mac[8*i +: 8];
            n++;
        end
        exp_bytes[n]     = 8'h08;           // ipv4 ethertype
        exp_bytes[n + 1] = 8'h00;
        n += 2;
        ip_hw[0] = 16'h4500;
        ip_hw[1] = cfg_data_len + 16'd28;
        ip_hw[2] = 16'h0000;
        ip_hw[3] = 16'h4000;
        ip_hw[4] = 16'h4011;                // ttl 64 and udp
        ip_hw[5] = 16'h0000;
        ip_hw[6] = cfg_src_ip[31:16];
        ip_hw[7] = cfg_src_ip[15:0];
        ip_hw[8] = cfg_det_ip[31:16];
        ip_hw[9] = cfg_det_ip[15:0];
        sum = 32'd0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0000, ip_hw[i]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        ip_hw[5] = ~sum[15:0];
        udp_hw[0] = cfg_src_port;
        udp_hw[1] = cfg_det_port;
        udp_hw[2] = cfg_data_len + 16'd8;
        udp_hw[3] = 16'h0000;
        for (int i = 0; i < 10; i++) begin
            exp_bytes[n]     = ip_hw[i][15:8];
            exp_bytes[n + 1] = ip_hw[i][7:0];
            n += 2;
        end
        for (int i = 0; i < 4; i++) begin
            exp_bytes[n]     = udp_hw[i][15:8];
            exp_bytes[n + 1] = udp_hw[i][7:0];
            n += 2;
        end
        for (int i = 0; i < int'(cfg_data_len); i++) begin
            exp_bytes[n] = payload[i];
            n++;
        end
        crc = 32'hffffffff;
        for (int i = 8; i < n; i++) begin
            crc = fcs_step(crc, exp_bytes[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_bytes[n] = crc[8*i +: 8];
            n++;
        end
        return n;
    endfunction

    // compare every byte while tx_rdy is high
    always @(negedge clk) begin
        if (reset) begin
            rdy_q    = 1'b0;
            rx_idx   = 0;
            rxen_cnt = 0;
        end else begin
            if (tx_rdy && !rdy_q) begin
                rx_idx   = 0;
                rxen_cnt = 0;
            end
            if (tx_rdy) begin
                if (rx_idx >= exp_len) begin
                    $display("tx_rdy still high after %0d expected bytes", exp_len);
                    $display("test failed");
                    $fatal(1);
                end
                check_byte($sformatf("txd[%0d]", rx_idx), txd, exp_bytes[rx_idx]);
                rx_idx = rx_idx + 1;
            end
            if (fifo_rxen) begin
                rxen_cnt = rxen_cnt + 1;
            end
            if (fd) begin
                check_len("tx_rdy cycles", 16'(rx_idx), 16'(exp_len));
                check_len("fifo_rxen cycles", 16'(rxen_cnt), data_len);
            end
            rdy_q = tx_rdy;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic pick_random_cfg();
        logic [31:0] r;
        cfg_src_mac  = {16'($random(seed)), 32'($random(seed))};
        cfg_det_mac  = {16'($random(seed)), 32'($random(seed))};
        cfg_src_ip   = 32'($random(seed));
        cfg_det_ip   = 32'($random(seed));
        cfg_src_port = 16'($random(seed));
        cfg_det_port = 16'($random(seed));
        r            = 32'($random(seed));
        cfg_data_len = 16'd18 + (r[15:0] % 16'd183);    // 18 to 200
    endtask

    task automatic launch_frame();
        @(posedge clk);
        for (int i = 0; i < 256; i++) begin
            payload[i] = 8'($random(seed));
        end
        exp_len = build_frame();
        src_mac     <= cfg_src_mac;
        det_mac     <= cfg_det_mac;
        src_ip_addr <= cfg_src_ip;
        det_ip_addr <= cfg_det_ip;
        src_ip_port <= cfg_src_port;
        det_ip_port <= cfg_det_port;
        data_len    <= cfg_data_len;
        fs          <= 1'b1;
        @(posedge clk);
        fs <= 1'b0;
    endtask

    task automatic pulse_fs();
        @(posedge clk);
        fs <= 1'b1;
        @(posedge clk);
        fs <= 1'b0;
    endtask

    task automatic wait_tx_rdy(input int max_cycles);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got && n < max_cycles) begin
            @(negedge clk);
            got = tx_rdy;
            n++;
        end
        if (!got) begin
            $display("timeout waiting for tx_rdy to rise");
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic wait_fd(input int max_cycles);
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got && n < max_cycles) begin
            @(negedge clk);
            got = fd;
            n++;
        end
        if (!got) begin
            $display("timeout waiting for fd at the end of the frame");
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_bit("tx_rdy", tx_rdy, 1'b0);
            check_bit("fd", fd, 1'b0);
            check_bit("fifo_rxen", fifo_rxen, 1'b0);
            check_byte("txd", txd, 8'h00);
        end
    endtask

    initial begin
        seed        = 32'h19af;
        reset       = 1'b1;
        fs          = 1'b0;
        src_mac     = 48'd0;
        det_mac     = 48'd0;
        src_ip_addr = 32'd0;
        det_ip_addr = 32'd0;
        src_ip_port = 16'd0;
        det_ip_port = 16'd0;
        data_len    = 16'd0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        check_quiet(20);

        // shortest frame gives 72 bytes on the line
        cfg_src_mac  = 48'h02_00_00_00_00_01;
        cfg_det_mac  = 48'h02_00_00_00_00_02;
        cfg_src_ip   = 32'hc0a8_0001;
        cfg_det_ip   = 32'hc0a8_0002;
        cfg_src_port = 16'd1234;
        cfg_det_port = 16'd5678;
        cfg_data_len = 16'd18;
        launch_frame();
        wait_tx_rdy(10);
        wait_fd(400);

        for (int i = 0; i < 10; i++) begin
            pick_random_cfg();
            launch_frame();
            wait_tx_rdy(10);
            wait_fd(400);
        end

        // stray fs while busy
        pick_random_cfg();
        launch_frame();
        wait_tx_rdy(10);
        repeat (30) @(posedge clk);
        pulse_fs();
        wait_fd(400);
        check_quiet(40);

        // back to back frames with fs right after fd
        pick_random_cfg();
        launch_frame();
        wait_fd(400);
        pick_random_cfg();
        launch_frame();
        wait_fd(400);
        check_quiet(10);

        $display("test passed");
        $finish;
    end

endmodule

//--- mac_tx_top.f
design/eth_tx_pkg.sv
design/crc32.sv
design/udp_tx.sv
design/ip_tx.sv
design/mac_tx.sv
design/frame_tx.sv
design/mac_tx_top.sv
sim/mac_tx_props.sv
sim/tb_mac_tx_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator; exit status carries the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mac_tx_top \
    -f mac_tx_top.f \
    -Mdir obj_dir -o tb_mac_tx_top

./obj_dir/tb_mac_tx_top
